//--- rtl/autotest_pkg.sv
// autotest shared definitions
// vector record layout, widths and sequencer states
`default_nettype none

package autotest_pkg;

  localparam int BLOCK_W = 64;
  localparam int KEY_W   = 80;
  localparam int TIMER_W = 64;

  localparam logic [31:0] SIGNATURE   = 32'hAABB_CCDD;
  localparam logic [31:0] START_BLOCK = 32'h0010_0000;

  // byte offsets inside the vector record
  localparam int SIG_OFS   = 0;
  localparam int BLOCK_OFS = 4;
  localparam int KEY_OFS   = 12;
  localparam int MODE_OFS  = 22;
  localparam int EXP_OFS   = 23;

  localparam int RECORD_BYTES = 31;
  // result then cycle count, lsb first
  localparam int RESULT_BYTES = 16;

  typedef logic [15:0] byte_idx_t;

  typedef enum logic [2:0] {
    INIT,
    HOST_RESET,
    LOAD,
    CHECK_SIG,
    RUN,
    STORE,
    NEXT,
    HALT
  } seq_state_t;

endpackage

`default_nettype wire

//--- rtl/byte_bus_if.sv
// byte bus between sequencer, sd transfer engine and data units
// requests, completion and per-byte traffic
`timescale 1ns/1ps
`default_nettype none

interface byte_bus_if;
  import autotest_pkg::*;

  // single-cycle requests from the sequencer
  logic      host_rst_req;
  logic      read_req;
  logic      write_req;

  logic      done;
  logic      rd_strobe;
  logic [7:0] rd_data;
  logic      wr_take;
  byte_idx_t idx;
  logic [7:0] wr_data;

  modport seq (
    output host_rst_req, read_req, write_req,
    input  done
  );

  modport engine (
    input  host_rst_req, read_req, write_req, wr_data,
    output done, rd_strobe, rd_data, wr_take, idx
  );

  modport source (input idx, output wr_data);

  modport sink (input rd_strobe, rd_data, idx);

endinterface

`default_nettype wire

//--- rtl/sd_transfer.sv
// sd transfer engine
// request/busy handshake with the spi host for reset, block read and block write
`timescale 1ns/1ps
`default_nettype none

module sd_transfer (
  input  wire        clk,
  input  wire        rst,
  byte_bus_if.engine bus,
  input  wire        sd_busy_i,
  input  wire  [7:0] sd_rd_data_i,
  output logic       sd_rst_o,
  output logic       sd_rd_block_o,
  output logic       sd_rd_byte_o,
  output logic       sd_wr_block_o,
  output logic       sd_wr_byte_o,
  output logic [7:0] sd_wr_data_o
);
  import autotest_pkg::*;

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_RST_REQ,
    ST_RST_WAIT,
    ST_BLK_REQ,
    ST_BLK_WAIT,
    ST_LAUNCH,
    ST_BYTE_REQ,
    ST_BYTE_WAIT,
    ST_CLOSE
  } xfer_state_t;

  xfer_state_t state_q;
  logic        wr_q;
  byte_idx_t   cnt_q;
  byte_idx_t   last_idx;
  logic        in_block;
  logic [7:0]  wdata_q;

  assign last_idx = wr_q ? byte_idx_t'(RESULT_BYTES - 1) : byte_idx_t'(RECORD_BYTES - 1);
  assign in_block = state_q inside {ST_BLK_REQ, ST_BLK_WAIT, ST_LAUNCH, ST_BYTE_REQ,
                                    ST_BYTE_WAIT};

  // request levels towards the host
  assign sd_rst_o      = (state_q == ST_RST_REQ);
  assign sd_rd_block_o = in_block && !wr_q;
  assign sd_wr_block_o = in_block && wr_q;
  assign sd_rd_byte_o  = (state_q == ST_BYTE_REQ) && !wr_q;
  assign sd_wr_byte_o  = (state_q == ST_BYTE_REQ) && wr_q;
  assign sd_wr_data_o  = wdata_q;

  assign bus.idx       = cnt_q;
  assign bus.rd_data   = sd_rd_data_i;
  // read byte is valid on the cycle busy falls
  assign bus.rd_strobe = (state_q == ST_BYTE_WAIT) && !sd_busy_i && !wr_q;
  assign bus.wr_take   = (state_q == ST_LAUNCH);
  assign bus.done      = (state_q == ST_CLOSE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
      wr_q    <= 1'b0;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          cnt_q <= '0;
          if (bus.host_rst_req) begin
            state_q <= ST_RST_REQ;
          end else if (bus.read_req) begin
            wr_q    <= 1'b0;
            state_q <= ST_BLK_REQ;
          end else if (bus.write_req) begin
            wr_q    <= 1'b1;
            state_q <= ST_BLK_REQ;
          end
        end
        ST_RST_REQ:  if (sd_busy_i) state_q <= ST_RST_WAIT;
        ST_RST_WAIT: if (!sd_busy_i) state_q <= ST_CLOSE;
        ST_BLK_REQ:  if (sd_busy_i) state_q <= ST_BLK_WAIT;
        ST_BLK_WAIT: if (!sd_busy_i) state_q <= wr_q ? ST_LAUNCH : ST_BYTE_REQ;
        ST_LAUNCH:   state_q <= ST_BYTE_REQ;
        ST_BYTE_REQ: if (sd_busy_i) state_q <= ST_BYTE_WAIT;
        ST_BYTE_WAIT: begin
          if (!sd_busy_i) begin
            if (cnt_q == last_idx) begin
              state_q <= ST_CLOSE;
            end else begin
              cnt_q   <= cnt_q + 1'b1;
              state_q <= wr_q ? ST_LAUNCH : ST_BYTE_REQ;
            end
          end
        end
        ST_CLOSE:    state_q <= ST_IDLE;
        default:     state_q <= ST_IDLE;
      endcase
    end
  end

  // held until the next launch
  always_ff @(posedge clk) begin
    if (state_q == ST_LAUNCH) begin
      wdata_q <= bus.wr_data;
    end
  end

endmodule

`default_nettype wire

//--- rtl/vector_store.sv
// vector store
// loads record bytes into the cipher operands and judges the signature
`timescale 1ns/1ps
`default_nettype none

module vector_store #(
  parameter int BLOCK_W = autotest_pkg::BLOCK_W,
  parameter int KEY_W   = autotest_pkg::KEY_W
) (
  input  wire                clk,
  input  wire                rst,
  byte_bus_if.sink           bus,
  output logic [BLOCK_W-1:0] block_o,
  output logic [KEY_W-1:0]   key_o,
  output logic               decrypt_o,
  output logic [BLOCK_W-1:0] expected_o,
  output logic               sig_ok_o
);
  import autotest_pkg::*;

  logic [31:0]        sig_q;
  logic [BLOCK_W-1:0] block_q;
  logic [BLOCK_W-1:0] expected_q;
  logic [KEY_W-1:0]   key_q;
  logic               decrypt_q;

  // signature arrives msb first
  always_ff @(posedge clk) begin
    if (rst) begin
      sig_q <= '0;
    end else if (bus.rd_strobe) begin
      for (int i = 0; i < 4; i++) begin
        if (bus.idx == byte_idx_t'(SIG_OFS + i))
          sig_q[8*(3-i) +: 8] <= bus.rd_data;
      end
    end
  end

  // operand fields, lsb first
  always_ff @(posedge clk) begin
    if (bus.rd_strobe) begin
      for (int i = 0; i < BLOCK_W/8; i++) begin
        if (bus.idx == byte_idx_t'(BLOCK_OFS + i))
          block_q[8*i +: 8] <= bus.rd_data;
        if (bus.idx == byte_idx_t'(EXP_OFS + i))
          expected_q[8*i +: 8] <= bus.rd_data;
      end
      for (int i = 0; i < KEY_W/8; i++) begin
        if (bus.idx == byte_idx_t'(KEY_OFS + i))
          key_q[8*i +: 8] <= bus.rd_data;
      end
      if (bus.idx == byte_idx_t'(MODE_OFS))
        decrypt_q <= bus.rd_data[0];
    end
  end

  assign block_o    = block_q;
  assign key_o      = key_q;
  assign decrypt_o  = decrypt_q;
  assign expected_o = expected_q;
  assign sig_ok_o   = (sig_q == SIGNATURE);

endmodule

`default_nettype wire

//--- rtl/result_unit.sv
// result unit
// times the cipher core, checks its result and serves the result record
`timescale 1ns/1ps
`default_nettype none

module result_unit #(
  parameter int BLOCK_W = autotest_pkg::BLOCK_W
) (
  input  wire                clk,
  input  wire                rst,
  byte_bus_if.source         bus,
  input  wire                run_i,
  input  wire                uut_end_i,
  input  wire  [BLOCK_W-1:0] uut_block_i,
  input  wire  [BLOCK_W-1:0] expected_i,
  output logic               finish_o,
  output logic [31:0]        error_count_o
);
  import autotest_pkg::*;

  logic               run_q;
  logic               seen_q;
  logic               capture;
  logic [TIMER_W-1:0] timer_q;
  logic [BLOCK_W-1:0] result_q;

  // first edge with the end flag high in this run
  assign capture = run_i && uut_end_i && !seen_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      run_q         <= 1'b0;
      seen_q        <= 1'b0;
      finish_o      <= 1'b0;
      error_count_o <= '0;
    end else begin
      run_q    <= run_i;
      finish_o <= capture;
      if (!run_i)
        seen_q <= 1'b0;
      else if (uut_end_i)
        seen_q <= 1'b1;
      if (capture && (uut_block_i != expected_i))
        error_count_o <= error_count_o + 1'b1;
    end
  end

  // run rise edge already counts when the core is still busy
  always_ff @(posedge clk) begin
    if (run_i && !run_q)
      timer_q <= {{(TIMER_W-1){1'b0}}, !uut_end_i};
    else if (run_i && !uut_end_i && !seen_q)
      timer_q <= timer_q + 1'b1;
    if (capture)
      result_q <= uut_block_i;
  end

  always_comb begin
    bus.wr_data = 8'h00;
    for (int i = 0; i < BLOCK_W/8; i++) begin
      if (bus.idx == byte_idx_t'(i))
        bus.wr_data = result_q[8*i +: 8];
    end
    for (int i = 0; i < TIMER_W/8; i++) begin
      if (bus.idx == byte_idx_t'(BLOCK_W/8 + i))
        bus.wr_data = timer_q[8*i +: 8];
    end
  end

endmodule

`default_nettype wire

//--- rtl/autotest_sequencer.sv
// autotest sequencer
// steps through host reset, vector load, check, run, store and next block
`timescale 1ns/1ps
`default_nettype none

module autotest_sequencer (
  input  wire         clk,
  input  wire         rst,
  byte_bus_if.seq     bus,
  input  wire         sig_ok_i,
  input  wire         finish_i,
  output logic        run_o,
  output logic        halted_o,
  output logic [31:0] block_addr_o
);
  import autotest_pkg::*;

  seq_state_t  state_q;
  logic [31:0] addr_q;
  logic        host_rst_q;
  logic        read_q;
  logic        write_q;

  // requests go out one cycle after the transition when the engine is idle again
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= INIT;
      addr_q     <= START_BLOCK;
      host_rst_q <= 1'b0;
      read_q     <= 1'b0;
      write_q    <= 1'b0;
    end else begin
      host_rst_q <= 1'b0;
      read_q     <= 1'b0;
      write_q    <= 1'b0;
      case (state_q)
        INIT: begin
          host_rst_q <= 1'b1;
          state_q    <= HOST_RESET;
        end
        HOST_RESET: begin
          if (bus.done) begin
            read_q  <= 1'b1;
            state_q <= LOAD;
          end
        end
        LOAD:      if (bus.done) state_q <= CHECK_SIG;
        CHECK_SIG: state_q <= sig_ok_i ? RUN : HALT;
        RUN: begin
          if (finish_i) begin
            write_q <= 1'b1;
            state_q <= STORE;
          end
        end
        STORE:     if (bus.done) state_q <= NEXT;
        NEXT: begin
          addr_q  <= addr_q + 32'd2;
          read_q  <= 1'b1;
          state_q <= LOAD;
        end
        HALT:      state_q <= HALT;
        default:   state_q <= INIT;
      endcase
    end
  end

  assign bus.host_rst_req = host_rst_q;
  assign bus.read_req     = read_q;
  assign bus.write_req    = write_q;

  assign run_o        = (state_q == RUN);
  assign halted_o     = (state_q == HALT);
  // results go to the odd block after the vector
  assign block_addr_o = (state_q == STORE) ? addr_q + 32'd1 : addr_q;

endmodule

`default_nettype wire

//--- rtl/sd_autotest_top.sv
// sd autotest top level
// self-test controller feeding sd card vectors to a 64-bit block cipher core
`timescale 1ns/1ps
`default_nettype none

module sd_autotest_top #(
  parameter int BLOCK_W = autotest_pkg::BLOCK_W,
  parameter int KEY_W   = autotest_pkg::KEY_W
) (
  input  wire                clk,
  input  wire                rst,
  input  wire                sd_busy_i,
  output logic [31:0]        sd_block_addr_o,
  input  wire  [7:0]         sd_rd_data_i,
  output logic               sd_rst_o,
  output logic               sd_rd_block_o,
  output logic               sd_rd_byte_o,
  output logic [7:0]         sd_wr_data_o,
  output logic               sd_wr_block_o,
  output logic               sd_wr_byte_o,
  output logic               uut_rst_o,
  output logic [BLOCK_W-1:0] uut_block_o,
  output logic [KEY_W-1:0]   uut_key_o,
  output logic               uut_decrypt_o,
  input  wire  [BLOCK_W-1:0] uut_block_i,
  input  wire                uut_end_i,
  output logic [31:0]        error_count_o,
  output logic               halted_o
);

  logic               run;
  logic               sig_ok;
  logic               finish;
  logic [BLOCK_W-1:0] expected;

  byte_bus_if bus ();

  autotest_sequencer autotest_sequencer_i (
    .clk          (clk),
    .rst          (rst),
    .bus          (bus.seq),
    .sig_ok_i     (sig_ok),
    .finish_i     (finish),
    .run_o        (run),
    .halted_o     (halted_o),
    .block_addr_o (sd_block_addr_o)
  );

  sd_transfer sd_transfer_i (
    .clk           (clk),
    .rst           (rst),
    .bus           (bus.engine),
    .sd_busy_i     (sd_busy_i),
    .sd_rd_data_i  (sd_rd_data_i),
    .sd_rst_o      (sd_rst_o),
    .sd_rd_block_o (sd_rd_block_o),
    .sd_rd_byte_o  (sd_rd_byte_o),
    .sd_wr_block_o (sd_wr_block_o),
    .sd_wr_byte_o  (sd_wr_byte_o),
    .sd_wr_data_o  (sd_wr_data_o)
  );

  vector_store #(
    .BLOCK_W (BLOCK_W),
    .KEY_W   (KEY_W)
  ) vector_store_i (
    .clk        (clk),
    .rst        (rst),
    .bus        (bus.sink),
    .block_o    (uut_block_o),
    .key_o      (uut_key_o),
    .decrypt_o  (uut_decrypt_o),
    .expected_o (expected),
    .sig_ok_o   (sig_ok)
  );

  result_unit #(
    .BLOCK_W (BLOCK_W)
  ) result_unit_i (
    .clk           (clk),
    .rst           (rst),
    .bus           (bus.source),
    .run_i         (run),
    .uut_end_i     (uut_end_i),
    .uut_block_i   (uut_block_i),
    .expected_i    (expected),
    .finish_o      (finish),
    .error_count_o (error_count_o)
  );

  // core held in reset outside a run
  assign uut_rst_o = ~run;

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
// testbench clock generator
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS = 100
) (
  output logic clk_o
);

  initial clk_o = 1'b0;

  always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

`default_nettype wire

//--- sim/tb_sd_autotest.sv
// testbench for the sd autotest controller
// models the sd host and the cipher core, checks records written back
`timescale 1ns/1ps
`default_nettype none

module tb_sd_autotest;

  localparam int NVEC = 6;
  localparam int REC_BYTES = 31;
  localparam int RES_BYTES = 16;
  localparam logic [31:0] FIRST_BLOCK = 32'h0010_0000;

  logic        clk;
  logic        rst;
  logic        sd_busy_i;
  logic [7:0]  sd_rd_data_i;
  logic [63:0] uut_block_i;
  logic        uut_end_i;
  logic [31:0] sd_block_addr;
  logic        sd_rst;
  logic        sd_rd_block;
  logic        sd_rd_byte;
  logic [7:0]  sd_wr_data;
  logic        sd_wr_block;
  logic        sd_wr_byte;
  logic        uut_rst;
  logic [63:0] uut_block;
  logic [79:0] uut_key;
  logic        uut_decrypt;
  logic [31:0] error_count;
  logic        halted;

  // vector table with the zero block as last entry
  logic [7:0]  rec_mem [0:NVEC][0:REC_BYTES-1];
  logic [63:0] blk_v [0:NVEC-1];
  logic [79:0] key_v [0:NVEC-1];
  logic        mode_v [0:NVEC-1];
  int          lat_v [0:NVEC-1];
  logic [7:0]  wr_buf [0:RES_BYTES-1];
  logic [31:0] rng_state;
  int          bad_count;
  int          busy_left;
  int          rd_count;
  int          rd_bytes;
  int          wr_blocks;
  int          wr_bytes;
  logic        rd_blk_prev;
  logic        wr_blk_prev;
  logic        wr_req_prev;
  logic [7:0]  wr_hold;
  logic        core_on;
  int          core_cnt;
  int          cur;

  tb_clock_gen #(.PERIOD_NS(100)) tb_clock_gen_i (.clk_o(clk));

  sd_autotest_top sd_autotest_top_i (
    .clk (clk), .rst (rst), .sd_busy_i (sd_busy_i), .sd_block_addr_o (sd_block_addr),
    .sd_rd_data_i (sd_rd_data_i), .sd_rst_o (sd_rst), .sd_rd_block_o (sd_rd_block),
    .sd_rd_byte_o (sd_rd_byte), .sd_wr_data_o (sd_wr_data), .sd_wr_block_o (sd_wr_block),
    .sd_wr_byte_o (sd_wr_byte), .uut_rst_o (uut_rst), .uut_block_o (uut_block),
    .uut_key_o (uut_key), .uut_decrypt_o (uut_decrypt), .uut_block_i (uut_block_i),
    .uut_end_i (uut_end_i), .error_count_o (error_count), .halted_o (halted)
  );

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // xor with key low, rotate by mode, xor with key high
  function automatic logic [63:0] ref_cipher(input logic [63:0] blk, input logic [79:0] key,
                                             input logic dec);
    logic [63:0] x;
    x = blk ^ key[63:0];
    if (dec)
      x = {x[18:0], x[63:19]};
    else
      x = {x[50:0], x[63:51]};
    return x ^ {4{key[79:64]}};
  endfunction

  task automatic check_equal(input logic [79:0] actual, input logic [79:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s, got %0h, expected %0h", $time, what, actual,
               expected);
      $display("RESULT: FAIL");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic build_vectors();
    logic [31:0] r;
    logic [63:0] exp;
    for (int v = 0; v < NVEC; v++) begin
      r = next_rand();
      blk_v[v] = {next_rand(), next_rand()};
      key_v[v] = {r[15:0], next_rand(), next_rand()};
      mode_v[v] = r[20];
      exp = ref_cipher(blk_v[v], key_v[v], mode_v[v]);
      // two records carry a wrong expected value
      if (v == 1 || v == 4) begin
        exp = exp ^ 64'h0000_0100_0000_0000;
        bad_count++;
      end
      {rec_mem[v][0], rec_mem[v][1], rec_mem[v][2], rec_mem[v][3]} = 32'hAABB_CCDD;
      for (int i = 0; i < 8; i++) begin
        rec_mem[v][4 + i] = blk_v[v][8*i +: 8];
        rec_mem[v][23 + i] = exp[8*i +: 8];
      end
      for (int i = 0; i < 10; i++)
        rec_mem[v][12 + i] = key_v[v][8*i +: 8];
      rec_mem[v][22] = {7'b0, mode_v[v]};
    end
    for (int i = 0; i < REC_BYTES; i++)
      rec_mem[NVEC][i] = 8'h00;
  endtask

  task automatic close_write();
    logic [63:0] res;
    logic [63:0] cyc;
    check_equal(wr_bytes, RES_BYTES, "bytes in result block");
    check_equal(wr_blocks < NVEC, 1, "result block count");
    for (int i = 0; i < 8; i++) begin
      res[8*i +: 8] = wr_buf[i];
      cyc[8*i +: 8] = wr_buf[8 + i];
    end
    check_equal(res, ref_cipher(blk_v[wr_blocks], key_v[wr_blocks], mode_v[wr_blocks]),
                "result bytes");
    check_equal(cyc, lat_v[wr_blocks], "cycle count bytes");
    wr_blocks++;
  endtask

  task automatic host_step();
    if (sd_busy_i)
      check_equal(sd_rd_byte | sd_wr_byte, 0, "byte request while host busy");
    if (sd_wr_byte && wr_req_prev)
      check_equal(sd_wr_data, wr_hold, "write data held during request");
    if (rd_blk_prev && !sd_rd_block)
      check_equal(rd_bytes, REC_BYTES, "bytes read from vector block");
    if (wr_blk_prev && !sd_wr_block)
      close_write();
    if (sd_busy_i) begin
      busy_left--;
      if (busy_left == 0)
        sd_busy_i = 1'b0;
    end else if (sd_wr_byte && !wr_req_prev) begin
      // the host takes a write byte one cycle late
      check_equal(wr_bytes < RES_BYTES, 1, "write byte count");
      wr_buf[wr_bytes] = sd_wr_data;
      wr_hold = sd_wr_data;
      wr_bytes++;
    end else if (sd_rst || (sd_rd_block && !rd_blk_prev) || (sd_wr_block && !wr_blk_prev) ||
                 sd_rd_byte || sd_wr_byte) begin
      if (sd_rd_block && !rd_blk_prev) begin
        check_equal(rd_count <= NVEC, 1, "reads within vector table");
        check_equal(sd_block_addr, FIRST_BLOCK + 2 * rd_count, "vector block address");
        rd_count++;
        rd_bytes = 0;
      end else if (sd_wr_block && !wr_blk_prev) begin
        check_equal(sd_block_addr, FIRST_BLOCK + 2 * wr_blocks + 1, "result block address");
        wr_bytes = 0;
      end else if (sd_rd_byte) begin
        check_equal(rd_bytes < REC_BYTES, 1, "read byte count");
        sd_rd_data_i = rec_mem[rd_count - 1][rd_bytes];
        rd_bytes++;
      end
      busy_left = 1 + int'(next_rand() % 4);
      sd_busy_i = 1'b1;
    end
    rd_blk_prev = sd_rd_block;
    wr_blk_prev = sd_wr_block;
    wr_req_prev = sd_wr_byte;
  endtask

  task automatic core_step();
    if (uut_rst) begin
      core_on = 1'b0;
      uut_end_i = 1'b0;
      uut_block_i = '0;
    end else begin
      cur = rd_count - 1;
      check_equal(uut_block, blk_v[cur], "core block operand");
      check_equal(uut_key, key_v[cur], "core key operand");
      check_equal(uut_decrypt, mode_v[cur], "core mode operand");
      if (!core_on) begin
        core_on = 1'b1;
        core_cnt = 0;
        lat_v[cur] = 3 + int'(next_rand() % 38);
      end else if (!uut_end_i) begin
        core_cnt++;
        if (core_cnt == lat_v[cur]) begin
          uut_end_i = 1'b1;
          uut_block_i = ref_cipher(blk_v[cur], key_v[cur], mode_v[cur]);
        end
      end
    end
  endtask

  always @(negedge clk) begin
    if (!rst) begin
      host_step();
      core_step();
    end
  end

  initial begin
    repeat (NVEC * 2000) @(posedge clk);
    $display("timeout: controller did not halt within %0d cycles", NVEC * 2000);
    $display("RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    rst = 1'b1;
    sd_busy_i = 1'b0;
    sd_rd_data_i = '0;
    uut_block_i = '0;
    uut_end_i = 1'b0;
    rng_state = 32'd75393;
    bad_count = 0;
    busy_left = 0;
    rd_count = 0;
    rd_bytes = 0;
    wr_blocks = 0;
    wr_bytes = 0;
    rd_blk_prev = 1'b0;
    wr_blk_prev = 1'b0;
    wr_req_prev = 1'b0;
    wr_hold = '0;
    core_on = 1'b0;
    core_cnt = 0;
    build_vectors();
    repeat (8) @(negedge clk);
    check_equal({sd_rst, sd_rd_block, sd_rd_byte, sd_wr_block, sd_wr_byte}, 0,
                "sd requests in reset");
    check_equal(uut_rst, 1, "core reset in reset");
    check_equal(error_count, 0, "error count in reset");
    check_equal(halted, 0, "halted in reset");
    rst = 1'b0;
    while (halted !== 1'b1)
      @(negedge clk);
    // stay a while to catch stray writes after the halt
    repeat (20) @(negedge clk);
    check_equal(halted, 1, "halted stays high");
    check_equal(sd_wr_block, 0, "write block after halt");
    check_equal(rd_count, NVEC + 1, "vector blocks read");
    check_equal(wr_blocks, NVEC, "result blocks written");
    check_equal(error_count, bad_count, "error count");
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
rtl/autotest_pkg.sv
rtl/byte_bus_if.sv
rtl/sd_transfer.sv
rtl/vector_store.sv
rtl/result_unit.sv
rtl/autotest_sequencer.sv
rtl/sd_autotest_top.sv
sim/tb_clock_gen.sv
sim/tb_sd_autotest.sv
